// File: hdl/cpu_pkg.sv
/*
 * cpu package
 * widths, opcodes, jump conditions, the two views of an instruction
 * word and the request/result structs shared by the 16-bit core
 */
package cpu_pkg;

    localparam int addr_w = 24;
    localparam int data_w = 16;
    localparam int nregs  = 8;
    localparam int rsel_w = $clog2(nregs);

    // 13 and 14 are spare and execute as a no-op
    typedef enum logic [3:0] {
        OP_LDI  = 4'h0,
        OP_LDHI = 4'h1,
        OP_MOV  = 4'h2,
        OP_ADD  = 4'h3,
        OP_SUB  = 4'h4,
        OP_AND  = 4'h5,
        OP_OR   = 4'h6,
        OP_XOR  = 4'h7,
        OP_LD   = 4'h8,
        OP_ST   = 4'h9,
        OP_STB  = 4'ha,
        OP_JR   = 4'hb,
        OP_DJNZ = 4'hc,
        OP_HALT = 4'hf
    } opcode_e;

    // codes 5 to 7 never jump
    typedef enum logic [2:0] {
        CC_T  = 3'd0,
        CC_Z  = 3'd1,
        CC_NZ = 3'd2,
        CC_C  = 3'd3,
        CC_NC = 3'd4
    } cond_e;

    // MOV, ALU ops, LD rd,(rs), ST/STB (rs) <- rd
    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [5:0]  rsvd;
    } instr_rr_t;

    // LDI, LDHI, JR (rd holds the condition), DJNZ
    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  rd;
        logic        rsvd;
        logic [7:0]  imm;
    } instr_imm_t;

    typedef union packed {
        instr_rr_t  rr;
        instr_imm_t imm;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5,
        ALU_DEC  = 3'd6
    } alu_op_e;

    typedef struct packed {
        logic [data_w-1:0] res;
        logic              zero;
        logic              carry;
    } alu_res_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic              rd;
        logic              wr;
        logic              byte_wr;
    } mem_req_t;

endpackage

// File: hdl/cpu_alu.sv
/*
 * ALU
 * combinational 16-bit datapath for pass, add, sub, logic ops and
 * decrement, with zero and carry/borrow outputs
 */
`timescale 1ns/10ps

module cpu_alu (
    input  cpu_pkg::alu_op_e           op,
    input  logic [cpu_pkg::data_w-1:0] a,
    input  logic [cpu_pkg::data_w-1:0] b,
    output cpu_pkg::alu_res_t          res
);

    // one extra bit catches carry out and borrow
    logic [cpu_pkg::data_w:0] sum;
    logic [cpu_pkg::data_w:0] a_x;
    logic [cpu_pkg::data_w:0] b_x;

    assign a_x = {1'b0, a};
    assign b_x = {1'b0, b};

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: sum = a_x + b_x;
            cpu_pkg::ALU_SUB: sum = a_x - b_x;
            cpu_pkg::ALU_AND: sum = a_x & b_x;
            cpu_pkg::ALU_OR:  sum = a_x | b_x;
            cpu_pkg::ALU_XOR: sum = a_x ^ b_x;
            // borrows only when a is zero
            cpu_pkg::ALU_DEC: sum = a_x - 1'b1;
            default:          sum = b_x;
        endcase
    end

    // logic ops keep bit 16 clear so C reads 0
    assign res.res   = sum[cpu_pkg::data_w-1:0];
    assign res.zero  = (sum[cpu_pkg::data_w-1:0] == '0);
    assign res.carry = sum[cpu_pkg::data_w];

    // decode in the sequencer must always settle to a known op
    always_comb begin
        assert (!$isunknown(op));
    end

endmodule

// File: hdl/cpu_regs.sv
/*
 * register bank
 * eight 16-bit registers, the Z and C flags and a byte-wide
 * dump port for registers, program counter and flags
 */
`timescale 1ns/10ps

module cpu_regs (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       cen,
    input  logic [cpu_pkg::rsel_w-1:0] rd_sel,
    input  logic [cpu_pkg::rsel_w-1:0] rs_sel,
    output logic [cpu_pkg::data_w-1:0] rd_val,
    output logic [cpu_pkg::data_w-1:0] rs_val,
    input  logic                       wr_en,
    input  logic [cpu_pkg::rsel_w-1:0] wr_sel,
    input  logic [cpu_pkg::data_w-1:0] wr_val,
    input  logic                       flag_we,
    input  cpu_pkg::alu_res_t          alu_res,
    output logic                       flag_z,
    output logic                       flag_c,
    input  logic [cpu_pkg::data_w-1:0] pc,
    input  logic [7:0]                 dmp_addr,
    output logic [7:0]                 dmp_din
);

    logic [cpu_pkg::data_w-1:0] regs_q [cpu_pkg::nregs];
    logic [cpu_pkg::data_w-1:0] dmp_reg;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < cpu_pkg::nregs; i++) begin
                regs_q[i] <= '0;
            end
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end else if (cen) begin
            if (wr_en) begin
                regs_q[wr_sel] <= wr_val;
            end
            if (flag_we) begin
                flag_z <= alu_res.zero;
                flag_c <= alu_res.carry;
            end
        end
    end

    assign rd_val = regs_q[rd_sel];
    assign rs_val = regs_q[rs_sel];

    // dump map: 0-15 registers low byte first, 16-17 pc, 18 flags
    assign dmp_reg = regs_q[dmp_addr[cpu_pkg::rsel_w:1]];

    always_comb begin
        if (dmp_addr < 8'(2 * cpu_pkg::nregs)) begin
            dmp_din = dmp_addr[0] ? dmp_reg[15:8] : dmp_reg[7:0];
        end else begin
            case (dmp_addr)
                8'd16:   dmp_din = pc[7:0];
                8'd17:   dmp_din = pc[15:8];
                8'd18:   dmp_din = {6'd0, flag_c, flag_z};
                default: dmp_din = 8'h00;
            endcase
        end
    end

endmodule

// File: hdl/cpu_memctl.sv
/*
 * memory controller
 * registers sequencer requests onto the RAM port, steers byte
 * stores to their lane and returns the word read back
 */
`timescale 1ns/10ps

module cpu_memctl (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       cen,
    input  cpu_pkg::mem_req_t          req,
    output logic [cpu_pkg::data_w-1:0] rdata,
    output logic [cpu_pkg::addr_w-1:0] ram_addr,
    input  logic [cpu_pkg::data_w-1:0] ram_dout,
    output logic [cpu_pkg::data_w-1:0] ram_din,
    output logic [1:0]                 ram_we
);

    logic                       rd_pend;
    logic [cpu_pkg::data_w-1:0] rdata_q;
    logic [1:0]                 lanes;

    // lane enables of the incoming request
    always_comb begin
        lanes = 2'b00;
        if (req.wr) begin
            if (!req.byte_wr) begin
                lanes = 2'b11;
            end else if (req.addr[0]) begin
                lanes = 2'b10;
            end else begin
                lanes = 2'b01;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ram_we  <= 2'b00;
            rd_pend <= 1'b0;
        end else if (cen) begin
            ram_we  <= lanes;
            rd_pend <= req.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (cen && (req.rd || req.wr)) begin
            ram_addr <= {req.addr[cpu_pkg::addr_w-1:1], 1'b0};
        end
        // byte data goes out on both halves, ram_we picks the lane
        if (cen && req.wr) begin
            ram_din <= req.byte_wr ? {2{req.wdata[7:0]}} : req.wdata;
        end
        if (cen && rd_pend) begin
            rdata_q <= ram_dout;
        end
    end

    // live RAM word while the read is pending, the captured copy after it
    assign rdata = rd_pend ? ram_dout : rdata_q;

    // a store strobes the RAM for a single enabled cycle
    assert property (@(posedge clk) disable iff (!arst_n)
        cen && (ram_we != 2'b00) |=> ram_we == 2'b00);

    // sequencer never reads and writes at once
    assert property (@(posedge clk) disable iff (!arst_n)
        !(req.rd && req.wr));

endmodule

// File: hdl/cpu_ctrl.sv
/*
 * instruction sequencer
 * fetch/decode/execute/wait phases, program counter, condition
 * test, ALU operand steering and register write control
 */
`timescale 1ns/10ps

module cpu_ctrl (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       cen,
    output cpu_pkg::mem_req_t          req,
    input  logic [cpu_pkg::data_w-1:0] rdata,
    output logic [cpu_pkg::rsel_w-1:0] rd_sel,
    output logic [cpu_pkg::rsel_w-1:0] rs_sel,
    input  logic [cpu_pkg::data_w-1:0] rd_val,
    input  logic [cpu_pkg::data_w-1:0] rs_val,
    output logic                       wr_en,
    output logic [cpu_pkg::rsel_w-1:0] wr_sel,
    output logic [cpu_pkg::data_w-1:0] wr_val,
    output logic                       flag_we,
    output cpu_pkg::alu_op_e           alu_op,
    output logic [cpu_pkg::data_w-1:0] alu_b,
    input  cpu_pkg::alu_res_t          alu_res,
    input  logic                       flag_z,
    input  logic                       flag_c,
    output logic [cpu_pkg::data_w-1:0] pc,
    output logic                       halted
);

    localparam int pad_w = cpu_pkg::addr_w - cpu_pkg::data_w;

    typedef enum logic [2:0] {S_FETCH, S_DECODE, S_EXEC, S_WAIT, S_HALT} phase_e;

    phase_e                     phase;
    cpu_pkg::instr_u            instr_q;
    cpu_pkg::instr_u            fetched;
    cpu_pkg::opcode_e           op;
    logic [cpu_pkg::data_w-1:0] simm;
    logic                       in_exec;
    logic                       writes_rd;
    logic                       sets_flags;
    logic                       cc_ok;
    logic                       jump;

    assign fetched = rdata;
    assign op      = instr_q.rr.opcode;
    assign simm    = {{(cpu_pkg::data_w-8){instr_q.imm.imm[7]}}, instr_q.imm.imm};
    assign in_exec = (phase == S_EXEC);
    assign halted  = (phase == S_HALT);
    assign rd_sel  = instr_q.rr.rd;
    assign rs_sel  = instr_q.rr.rs;
    assign wr_sel  = instr_q.rr.rd;

    // operand a is always rd so only b and the operation vary here
    always_comb begin
        alu_op     = cpu_pkg::ALU_PASS;
        alu_b      = rs_val;
        writes_rd  = 1'b0;
        sets_flags = 1'b0;
        case (op)
            cpu_pkg::OP_LDI: begin
                alu_b     = simm;
                writes_rd = 1'b1;
            end
            cpu_pkg::OP_LDHI: begin
                alu_b     = {instr_q.imm.imm, rd_val[7:0]};
                writes_rd = 1'b1;
            end
            cpu_pkg::OP_MOV:  writes_rd = 1'b1;
            cpu_pkg::OP_ADD:  alu_op = cpu_pkg::ALU_ADD;
            cpu_pkg::OP_SUB:  alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_AND:  alu_op = cpu_pkg::ALU_AND;
            cpu_pkg::OP_OR:   alu_op = cpu_pkg::ALU_OR;
            cpu_pkg::OP_XOR:  alu_op = cpu_pkg::ALU_XOR;
            cpu_pkg::OP_DJNZ: alu_op = cpu_pkg::ALU_DEC;
            default: ;
        endcase
        if (alu_op != cpu_pkg::ALU_PASS) begin
            writes_rd  = 1'b1;
            sets_flags = 1'b1;
        end
    end

    // load data lands in WAIT and everything else in EXEC
    assign wr_en   = (in_exec && writes_rd) || (phase == S_WAIT);
    assign wr_val  = (phase == S_WAIT) ? rdata : alu_res.res;
    assign flag_we = in_exec && sets_flags;

    always_comb begin
        case (cpu_pkg::cond_e'(instr_q.imm.rd))
            cpu_pkg::CC_T:  cc_ok = 1'b1;
            cpu_pkg::CC_Z:  cc_ok = flag_z;
            cpu_pkg::CC_NZ: cc_ok = !flag_z;
            cpu_pkg::CC_C:  cc_ok = flag_c;
            cpu_pkg::CC_NC: cc_ok = !flag_c;
            default:        cc_ok = 1'b0;
        endcase
    end

    // DJNZ tests the decremented value rather than the old flag
    assign jump = in_exec && ((op == cpu_pkg::OP_JR && cc_ok) ||
                              (op == cpu_pkg::OP_DJNZ && !alu_res.zero));

    always_comb begin
        req         = '0;
        req.wdata   = rd_val;
        req.byte_wr = (op == cpu_pkg::OP_STB);
        if (phase == S_FETCH) begin
            req.addr = {{pad_w{1'b0}}, pc};
            req.rd   = cen;
        end else if (in_exec) begin
            req.addr = {{pad_w{1'b0}}, rs_val};
            req.rd   = cen && (op == cpu_pkg::OP_LD);
            req.wr   = cen && (op == cpu_pkg::OP_ST || op == cpu_pkg::OP_STB);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase   <= S_FETCH;
            pc      <= '0;
            instr_q <= '0;
        end else if (cen) begin
            case (phase)
                S_FETCH: phase <= S_DECODE;
                S_DECODE: begin
                    instr_q <= fetched;
                    pc      <= pc + 16'd2;
                    phase   <= (fetched.rr.opcode == cpu_pkg::OP_HALT) ? S_HALT : S_EXEC;
                end
                S_EXEC: begin
                    if (jump) begin
                        pc <= pc + {simm[cpu_pkg::data_w-2:0], 1'b0};
                    end
                    phase <= (op == cpu_pkg::OP_LD) ? S_WAIT : S_FETCH;
                end
                S_WAIT:  phase <= S_FETCH;
                default: phase <= S_HALT;
            endcase
        end
    end

    // register writes come from EXEC or from the WAIT that follows a load
    assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> (phase == S_EXEC) || (phase == S_WAIT && op == cpu_pkg::OP_LD));

    // halt is sticky and the bus stays idle
    assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> halted && !req.rd && !req.wr);

endmodule

// File: hdl/cpu_top.sv
/*
 * 16-bit load/store core
 * sequencer, register bank, ALU and memory controller on a
 * single RAM port, with a byte-wide register dump
 */
`timescale 1ns/10ps

module cpu_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       cen,
    output logic [cpu_pkg::addr_w-1:0] ram_addr,
    input  logic [cpu_pkg::data_w-1:0] ram_dout,
    output logic [cpu_pkg::data_w-1:0] ram_din,
    output logic [1:0]                 ram_we,
    input  logic [7:0]                 dmp_addr,
    output logic [7:0]                 dmp_din,
    output logic                       halted
);

    cpu_pkg::mem_req_t          req;
    logic [cpu_pkg::data_w-1:0] rdata;
    logic [cpu_pkg::rsel_w-1:0] rd_sel;
    logic [cpu_pkg::rsel_w-1:0] rs_sel;
    logic [cpu_pkg::data_w-1:0] rd_val;
    logic [cpu_pkg::data_w-1:0] rs_val;
    logic                       wr_en;
    logic [cpu_pkg::rsel_w-1:0] wr_sel;
    logic [cpu_pkg::data_w-1:0] wr_val;
    logic                       flag_we;
    cpu_pkg::alu_op_e           alu_op;
    logic [cpu_pkg::data_w-1:0] alu_b;
    cpu_pkg::alu_res_t          alu_res;
    logic                       flag_z;
    logic                       flag_c;
    logic [cpu_pkg::data_w-1:0] pc;

    // ports and nets share names
    cpu_ctrl u_ctrl (.*);

    cpu_regs u_regs (.*);

    // operand a is always the rd register
    cpu_alu u_alu (
        .op     ( alu_op  ),
        .a      ( rd_val  ),
        .b      ( alu_b   ),
        .res    ( alu_res )
    );

    cpu_memctl u_memctl (.*);

endmodule

// File: tests/cpu_tb.sv
/*
 * testbench for the 16-bit core
 * random forward-only program in a RAM model, instruction-set model,
 * store, register, flag, halt and reset checks
 */
`timescale 1ns/10ps

module cpu_tb;

    localparam int prog_len   = 60;
    localparam int ram_words  = 16384;
    localparam int halt_limit = 40 * prog_len;

    typedef struct packed {
        logic [23:0] addr;
        logic [1:0]  we;
        logic [15:0] data;
    } store_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        cen;
    logic [23:0] ram_addr;
    logic [15:0] ram_dout;
    logic [15:0] ram_din;
    logic [1:0]  ram_we;
    logic [7:0]  dmp_addr;
    logic [7:0]  dmp_din;
    logic        halted;

    logic [15:0] ram [ram_words];
    logic [15:0] iss_mem [ram_words];
    logic        tgt_ok [prog_len];
    logic        is_jump [prog_len];
    logic [15:0] lfsr_q;
    logic        run_en;
    store_t      exp_stores [$];
    logic [15:0] m_regs [8];
    logic [15:0] m_pc;
    logic        m_z;
    logic        m_c;

    cpu_top dut_i (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .cen      ( cen      ),
        .ram_addr ( ram_addr ),
        .ram_dout ( ram_dout ),
        .ram_din  ( ram_din  ),
        .ram_we   ( ram_we   ),
        .dmp_addr ( dmp_addr ),
        .dmp_din  ( dmp_din  ),
        .halted   ( halted   )
    );

    always #10 clk = ~clk;

    // RAM answers combinationally from the registered address
    assign ram_dout = ram[ram_addr[14:1]];

    // galois LFSR stepped once per bit handed out
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[14:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    task automatic stop_failed();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_failed();
        end
    endtask

    // one dump address per cycle and read back at the falling edge
    task automatic read_dump(input logic [7:0] a, output logic [7:0] v);
        @(posedge clk);
        #2;
        dmp_addr = a;
        @(negedge clk);
        v = dmp_din;
    endtask

    task automatic build_program();
        int          i;
        int          k;
        int          off;
        logic [2:0]  rd_r;
        logic [2:0]  rs_r;
        logic [7:0]  imm_r;
        logic [1:0]  mem_sel;
        logic [5:0]  hi6;
        logic [3:0]  mop;
        for (int a = 0; a < ram_words; a++) begin
            ram[a] = 16'(a * 40503) ^ 16'h5a5a;
        end
        for (int j = 0; j < prog_len; j++) begin
            tgt_ok[j]  = 1'b1;
            is_jump[j] = 1'b0;
        end
        i = 0;
        while (i < prog_len - 1) begin
            k     = int'(rand_bits(4));
            rd_r  = 3'(rand_bits(3));
            rs_r  = 3'(rand_bits(3));
            imm_r = 8'(rand_bits(8));
            // a pointer setup plus access needs three slots before HALT
            if (k >= 9 && k <= 11 && i > prog_len - 4) begin
                k = 0;
            end
            case (k)
                0, 1: ram[i] = {cpu_pkg::OP_LDI, rd_r, 1'b0, imm_r};
                2:    ram[i] = {cpu_pkg::OP_LDHI, rd_r, 1'b0, imm_r};
                3:    ram[i] = {cpu_pkg::OP_MOV, rd_r, rs_r, 6'd0};
                4:    ram[i] = {cpu_pkg::OP_ADD, rd_r, rs_r, 6'd0};
                5:    ram[i] = {cpu_pkg::OP_AND, rd_r, rs_r, 6'd0};
                6:    ram[i] = {cpu_pkg::OP_OR, rd_r, rs_r, 6'd0};
                7:    ram[i] = {cpu_pkg::OP_XOR, rd_r, rs_r, 6'd0};
                8, 15: ram[i] = {cpu_pkg::OP_SUB, rd_r, rs_r, 6'd0};
                9, 10, 11: begin
                    mem_sel = 2'(rand_bits(2));
                    hi6     = 6'(rand_bits(6));
                    mop = (mem_sel == 2'd0) ? cpu_pkg::OP_LD :
                          (mem_sel == 2'd1) ? cpu_pkg::OP_ST : cpu_pkg::OP_STB;
                    // pointer lands in 0x4000..0x7fff
                    ram[i]     = {cpu_pkg::OP_LDI, rs_r, 1'b0, imm_r};
                    ram[i + 1] = {cpu_pkg::OP_LDHI, rs_r, 1'b0, 2'b01, hi6};
                    ram[i + 2] = {mop, rd_r, rs_r, 6'd0};
                    tgt_ok[i + 1] = 1'b0;
                    tgt_ok[i + 2] = 1'b0;
                    i += 2;
                end
                12, 13: begin
                    ram[i]     = {cpu_pkg::OP_JR, rd_r, 1'b0, 8'd0};
                    is_jump[i] = 1'b1;
                end
                default: begin
                    ram[i]     = {cpu_pkg::OP_DJNZ, rd_r, 1'b0, 8'd0};
                    is_jump[i] = 1'b1;
                end
            endcase
            i++;
        end
        ram[prog_len - 1] = {cpu_pkg::OP_HALT, 12'd0};
        // forward targets only and never inside a pointer setup
        for (int j = 0; j < prog_len - 1; j++) begin
            if (is_jump[j]) begin
                off = int'(rand_bits(6)) % (prog_len - 1 - j);
                while (!tgt_ok[j + 1 + off]) begin
                    off++;
                end
                ram[j][7:0] = 8'(off);
            end
        end
        for (int a = 0; a < ram_words; a++) begin
            iss_mem[a] = ram[a];
        end
    endtask

    task automatic run_model();
        logic [15:0] w;
        logic [15:0] pc;
        logic [15:0] simm;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [16:0] t;
        logic        alu;
        logic        take;
        logic        done;
        store_t      s;
        pc   = '0;
        m_z  = 1'b0;
        m_c  = 1'b0;
        done = 1'b0;
        for (int r = 0; r < 8; r++) begin
            m_regs[r] = '0;
        end
        while (!done) begin
            w    = iss_mem[pc[14:1]];
            pc   = pc + 16'd2;
            rd   = w[11:9];
            rs   = w[8:6];
            simm = {{8{w[7]}}, w[7:0]};
            alu  = 1'b0;
            take = 1'b0;
            s.addr = {8'd0, m_regs[rs][15:1], 1'b0};
            case (w[15:12])
                cpu_pkg::OP_LDI:  m_regs[rd] = simm;
                cpu_pkg::OP_LDHI: m_regs[rd] = {w[7:0], m_regs[rd][7:0]};
                cpu_pkg::OP_MOV:  m_regs[rd] = m_regs[rs];
                cpu_pkg::OP_ADD: begin
                    t   = {1'b0, m_regs[rd]} + {1'b0, m_regs[rs]};
                    alu = 1'b1;
                end
                cpu_pkg::OP_SUB: begin
                    t   = {1'b0, m_regs[rd]} - {1'b0, m_regs[rs]};
                    alu = 1'b1;
                end
                cpu_pkg::OP_AND: begin
                    t   = {1'b0, m_regs[rd] & m_regs[rs]};
                    alu = 1'b1;
                end
                cpu_pkg::OP_OR: begin
                    t   = {1'b0, m_regs[rd] | m_regs[rs]};
                    alu = 1'b1;
                end
                cpu_pkg::OP_XOR: begin
                    t   = {1'b0, m_regs[rd] ^ m_regs[rs]};
                    alu = 1'b1;
                end
                cpu_pkg::OP_LD: m_regs[rd] = iss_mem[m_regs[rs][14:1]];
                cpu_pkg::OP_ST: begin
                    s.we   = 2'b11;
                    s.data = m_regs[rd];
                    iss_mem[m_regs[rs][14:1]] = m_regs[rd];
                    exp_stores.push_back(s);
                end
                cpu_pkg::OP_STB: begin
                    s.we   = m_regs[rs][0] ? 2'b10 : 2'b01;
                    s.data = {2{m_regs[rd][7:0]}};
                    if (m_regs[rs][0]) begin
                        iss_mem[m_regs[rs][14:1]][15:8] = m_regs[rd][7:0];
                    end else begin
                        iss_mem[m_regs[rs][14:1]][7:0] = m_regs[rd][7:0];
                    end
                    exp_stores.push_back(s);
                end
                cpu_pkg::OP_JR: begin
                    case (rd)
                        cpu_pkg::CC_T:  take = 1'b1;
                        cpu_pkg::CC_Z:  take = m_z;
                        cpu_pkg::CC_NZ: take = !m_z;
                        cpu_pkg::CC_C:  take = m_c;
                        cpu_pkg::CC_NC: take = !m_c;
                        default:        take = 1'b0;
                    endcase
                end
                cpu_pkg::OP_DJNZ: begin
                    t    = {1'b0, m_regs[rd]} - 17'd1;
                    alu  = 1'b1;
                    take = (t[15:0] != 16'd0);
                end
                cpu_pkg::OP_HALT: done = 1'b1;
                default: begin
                    $display("model met opcode 0x%0h, which the program never holds", w[15:12]);
                    stop_failed();
                end
            endcase
            if (alu) begin
                m_regs[rd] = t[15:0];
                m_z = (t[15:0] == 16'd0);
                m_c = t[16];
            end
            if (take) begin
                pc = pc + {simm[14:0], 1'b0};
            end
        end
        m_pc = pc;
    endtask

    task automatic commit_store();
        store_t s;
        if (halted) begin
            $display("RAM write at %0t after the core halted", $time);
            stop_failed();
        end else if (exp_stores.size() == 0) begin
            $display("RAM write at %0t with no store left in the model", $time);
            stop_failed();
        end else begin
            s = exp_stores.pop_front();
            check_val("ram_addr", 32'(ram_addr), 32'(s.addr));
            check_val("ram_we", 32'(ram_we), 32'(s.we));
            check_val("ram_din", 32'(ram_din), 32'(s.data));
            if (ram_we[0]) begin
                ram[ram_addr[14:1]][7:0] = ram_din[7:0];
            end
            if (ram_we[1]) begin
                ram[ram_addr[14:1]][15:8] = ram_din[15:8];
            end
        end
    endtask

    // the strobe is taken on the enabled edge that ends it
    always @(negedge clk) begin
        if (arst_n && cen && ram_we != 2'b00) begin
            commit_store();
        end
    end

    // cen low on about one cycle in four once the core runs
    always @(posedge clk) begin
        if (run_en) begin
            #2;
            cen = (rand_bits(2) != 2'b00);
        end
    end

    initial begin
        logic [7:0] lo;
        logic [7:0] hi;
        int         cyc;
        int         en_cnt;
        arst_n   = 1'b0;
        cen      = 1'b0;
        dmp_addr = 8'd0;
        run_en   = 1'b0;
        lfsr_q   = 16'd67;
        build_program();
        run_model();

        // reset state and then still frozen by cen low after release
        for (int i = 0; i < 19; i++) begin
            if (i == 9) begin
                @(posedge clk);
                #2;
                arst_n = 1'b1;
            end
            read_dump(8'(i), lo);
            check_val("ram_we", 32'(ram_we), 32'd0);
            check_val("halted", 32'(halted), 32'd0);
            check_val($sformatf("dump[%0d]", i), 32'(lo), 32'd0);
        end

        run_en = 1'b1;
        cyc    = 0;
        en_cnt = 0;
        while (!halted) begin
            @(negedge clk);
            cyc++;
            if (cen) begin
                en_cnt++;
            end
            if (en_cnt > halt_limit || cyc > 4 * halt_limit) begin
                $display("halted did not rise within %0d enabled cycles", halt_limit);
                stop_failed();
            end
        end

        for (int r = 0; r < 8; r++) begin
            read_dump(8'(2 * r), lo);
            read_dump(8'(2 * r + 1), hi);
            check_val($sformatf("r%0d", r), 32'({hi, lo}), 32'(m_regs[r]));
        end
        read_dump(8'd16, lo);
        read_dump(8'd17, hi);
        check_val("pc", 32'({hi, lo}), 32'(m_pc));
        read_dump(8'd18, lo);
        check_val("flags", 32'(lo), 32'({m_c, m_z}));

        if (exp_stores.size() != 0) begin
            $display("%0d model stores never reached the RAM port", exp_stores.size());
            stop_failed();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: sim.f
hdl/cpu_pkg.sv
hdl/cpu_alu.sv
hdl/cpu_regs.sv
hdl/cpu_memctl.sv
hdl/cpu_ctrl.sv
hdl/cpu_top.sv
tests/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the core and its testbench with Verilator, run, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_tb -Mdir obj_dir -f sim.f

# a failed run exits nonzero, its output still goes to the search
out="$(./obj_dir/Vcpu_tb 2>&1 || true)"
echo "$out"

if grep -qx "Result: PASSED" <<< "$out"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
